/* common/mduPkg.sv */
package mduPkg;

    // architectural register and operand value
    typedef logic [31:0] word_t;

    // HI:LO pair or full 64-bit product
    typedef logic [63:0] dword_t;

    // latency counter
    typedef logic [3:0] count_t;

    // execute stage operation codes, 8..15 do nothing
    typedef enum logic [3:0]
    {
        OpMultu = 4'd0,
        OpMult  = 4'd1,
        OpDivu  = 4'd2,
        OpDiv   = 4'd3,
        OpMaddu = 4'd4,
        OpMadd  = 4'd5,
        OpMsubu = 4'd6,
        OpMsub  = 4'd7
    } mduOp_t;

    // mthi/mtlo move codes, code 2 does nothing
    typedef enum logic [1:0]
    {
        MoveNone = 2'd0,
        MoveLo   = 2'd1,
        MoveHi   = 2'd3
    } hiLoMove_t;

    // sequencer FSM
    typedef enum logic
    {
        SeqIdle = 1'b0,
        SeqRun  = 1'b1
    } seqState_t;

    // busy cycles per operation class
    localparam count_t MulLatency = 4'd5;
    localparam count_t DivLatency = 4'd10;

    // accumulate modes for the multiplier
    localparam logic [1:0] AccNone = 2'd0;
    localparam logic [1:0] AccAdd  = 2'd1;
    localparam logic [1:0] AccSub  = 2'd2;

endpackage

/* design/mduIssue.sv */
module mduIssue
    import mduPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       excHandle,
    input  mduOp_t     mduOp,
    input  hiLoMove_t  moveHiLo,
    input  logic       mduClr,
    input  logic       busy,
    output logic       start,
    output logic       startDiv,
    output logic       startSigned,
    output logic [1:0] accMode,
    output logic       writeHi,
    output logic       writeLo
);

    logic accept;
    logic opValid;

    // clear wins over busy, busy over an exception
    assign accept = !mduClr && !busy && !excHandle;

    always_comb
    begin
        opValid  = 1'b1;
        startDiv = 1'b0;
        accMode  = AccNone;
        case (mduOp)
            OpMultu, OpMult:
                accMode = AccNone;
            OpDivu, OpDiv:
                startDiv = 1'b1;
            OpMaddu, OpMadd:
                accMode = AccAdd;
            OpMsubu, OpMsub:
                accMode = AccSub;
            default:
                opValid = 1'b0;
        endcase
    end

    // odd codes are the signed variants
    assign startSigned = mduOp[0];

    assign start   = accept && opValid;
    assign writeHi = accept && (moveHiLo == MoveHi);
    assign writeLo = accept && (moveHiLo == MoveLo);

    // once started, the sequencer holds off the next command
    assert property (@(posedge clk) disable iff (reset)
        start |=> !(start || writeHi || writeLo))
    else $error("command accepted while busy");

endmodule

/* mduCore/mulAccUnit.sv */
module mulAccUnit
    import mduPkg::*;
(
    input  word_t      srcA,
    input  word_t      srcB,
    input  word_t      hi,
    input  word_t      lo,
    input  logic       startSigned,
    input  logic [1:0] accMode,
    output dword_t     mulResult
);

    dword_t extA;
    dword_t extB;
    dword_t product;
    dword_t hiLo;

    // sign or zero extend to 64 bits
    always_comb
    begin
        if (startSigned)
        begin
            extA = {{32{srcA[31]}}, srcA};
            extB = {{32{srcB[31]}}, srcB};
        end
        else
        begin
            extA = {32'b0, srcA};
            extB = {32'b0, srcB};
        end
    end

    // low 64 bits are the exact product in both cases
    assign product = extA * extB;

    assign hiLo = {hi, lo};

    always_comb
    begin
        case (accMode)
            AccAdd:
                mulResult = hiLo + product;
            AccSub:
                mulResult = hiLo - product;
            default:
                mulResult = product;
        endcase
    end

endmodule

/* mduCore/divUnit.sv */
module divUnit
    import mduPkg::*;
(
    input  word_t  srcA,
    input  word_t  srcB,
    input  logic   startSigned,
    output dword_t divResult
);

    logic signed [31:0] sA;
    logic signed [31:0] sB;
    word_t              quotient;
    word_t              remainder;

    assign sA = srcA;
    assign sB = srcB;

    // signed path truncates toward zero, remainder follows the dividend
    always_comb
    begin
        if (startSigned)
        begin
            quotient  = sA / sB;
            remainder = sA % sB;
        end
        else
        begin
            quotient  = srcA / srcB;
            remainder = srcA % srcB;
        end
    end

    // remainder goes to HI, quotient to LO
    assign divResult = {remainder, quotient};

endmodule

/* mduCore/mduSequencer.sv */
module mduSequencer
    import mduPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   mduClr,
    input  logic   start,
    input  logic   startDiv,
    input  dword_t mulResult,
    input  dword_t divResult,
    output logic   busy,
    output logic   commit,
    output dword_t commitValue
);

    seqState_t state;
    count_t    count;
    dword_t    result;

    always_ff @(posedge clk)
    begin
        if (reset || mduClr)
        begin
            state <= SeqIdle;
            count <= '0;
        end
        else if (state == SeqRun)
        begin
            if (count == count_t'(1))
            begin
                state <= SeqIdle;
            end
            count <= count - count_t'(1);
        end
        else if (start)
        begin
            state <= SeqRun;
            count <= startDiv ? DivLatency : MulLatency;
        end
    end

    // result is taken at issue and held for the whole latency
    always_ff @(posedge clk)
    begin
        if (start && state == SeqIdle)
        begin
            result <= startDiv ? divResult : mulResult;
        end
    end

    assign busy = (count != '0);

    // last run cycle writes HI/LO unless the op is being aborted
    assign commit      = (state == SeqRun) && (count == count_t'(1)) && !mduClr;
    assign commitValue = result;

    assert property (@(posedge clk) disable iff (reset)
        busy == (state == SeqRun))
    else $error("busy disagrees with sequencer state");

    assert property (@(posedge clk) disable iff (reset)
        commit |-> $past(busy) ##1 !busy)
    else $error("commit outside of a run");

    assert property (@(posedge clk) disable iff (reset)
        start |-> state == SeqIdle)
    else $error("start arrived during a run");

endmodule

/* design/hiLoFile.sv */
module hiLoFile
    import mduPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   commit,
    input  dword_t commitValue,
    input  logic   writeHi,
    input  logic   writeLo,
    input  word_t  srcA,
    output word_t  hi,
    output word_t  lo
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hi <= '0;
            lo <= '0;
        end
        else if (commit)
        begin
            hi <= commitValue[63:32];
            lo <= commitValue[31:0];
        end
        else
        begin
            // mthi / mtlo
            if (writeHi)
            begin
                hi <= srcA;
            end
            if (writeLo)
            begin
                lo <= srcA;
            end
        end
    end

    // commits only happen while busy, moves only while idle
    assert property (@(posedge clk) disable iff (reset)
        !(commit && (writeHi || writeLo)))
    else $error("commit and move in the same cycle");

endmodule

/* design/mduUnit.sv */
module mduUnit
    import mduPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      excHandle,
    input  mduOp_t    mduOp,
    input  hiLoMove_t moveHiLo,
    input  word_t     srcA,
    input  word_t     srcB,
    input  logic      mduClr,
    output word_t     hi,
    output word_t     lo,
    output logic      busy
);

    logic       start;
    logic       startDiv;
    logic       startSigned;
    logic [1:0] accMode;
    logic       writeHi;
    logic       writeLo;
    logic       commit;
    dword_t     mulResult;
    dword_t     divResult;
    dword_t     commitValue;

    mduIssue issue (
        .clk         (clk),
        .reset       (reset),
        .excHandle   (excHandle),
        .mduOp       (mduOp),
        .moveHiLo    (moveHiLo),
        .mduClr      (mduClr),
        .busy        (busy),
        .start       (start),
        .startDiv    (startDiv),
        .startSigned (startSigned),
        .accMode     (accMode),
        .writeHi     (writeHi),
        .writeLo     (writeLo)
    );

    // accumulate sees HI/LO as they stand at issue
    mulAccUnit mulAcc (
        .srcA        (srcA),
        .srcB        (srcB),
        .hi          (hi),
        .lo          (lo),
        .startSigned (startSigned),
        .accMode     (accMode),
        .mulResult   (mulResult)
    );

    divUnit div (
        .srcA        (srcA),
        .srcB        (srcB),
        .startSigned (startSigned),
        .divResult   (divResult)
    );

    mduSequencer sequencer (
        .clk         (clk),
        .reset       (reset),
        .mduClr      (mduClr),
        .start       (start),
        .startDiv    (startDiv),
        .mulResult   (mulResult),
        .divResult   (divResult),
        .busy        (busy),
        .commit      (commit),
        .commitValue (commitValue)
    );

    hiLoFile hiLo (
        .clk         (clk),
        .reset       (reset),
        .commit      (commit),
        .commitValue (commitValue),
        .writeHi     (writeHi),
        .writeLo     (writeLo),
        .srcA        (srcA),
        .hi          (hi),
        .lo          (lo)
    );

    // divide by zero leaves HI/LO unspecified
    assert property (@(posedge clk) disable iff (reset)
        (start && startDiv) |-> (srcB != '0))
    else $warning("divide issued with a zero divisor");

endmodule

/* test/mduRefModel.svh */
`ifndef MDU_REF_MODEL_SVH
`define MDU_REF_MODEL_SVH

// signed variants are mult, div, madd and msub
function automatic bit refIsSigned(input mduOp_t op);
    return op inside {OpMult, OpDiv, OpMadd, OpMsub};
endfunction

// full 64-bit product from 64-bit integer arithmetic
function automatic dword_t refProduct(input mduOp_t op, input word_t a, input word_t b);
    longint          signedA;
    longint          signedB;
    longint unsigned wideA;
    longint unsigned wideB;
    if (refIsSigned(op))
    begin
        signedA = longint'($signed(a));
        signedB = longint'($signed(b));
        return dword_t'(signedA * signedB);
    end
    wideA = a;
    wideB = b;
    return dword_t'(wideA * wideB);
endfunction

// divide on magnitudes, then fix the signs: quotient truncates toward zero,
// remainder keeps the sign of the dividend
function automatic dword_t refDivide(input mduOp_t op, input word_t a, input word_t b);
    word_t magA;
    word_t magB;
    word_t quotient;
    word_t remainder;
    if (!refIsSigned(op))
    begin
        return {a % b, a / b};
    end
    magA      = a[31] ? -a : a;
    magB      = b[31] ? -b : b;
    quotient  = magA / magB;
    remainder = magA % magB;
    if (a[31] != b[31])
        quotient = -quotient;
    if (a[31])
        remainder = -remainder;
    return {remainder, quotient};
endfunction

// expected HI:LO after one operation
function automatic dword_t refResult(input mduOp_t op, input word_t a, input word_t b,
                                     input dword_t hiLo);
    case (op)
        OpMultu, OpMult:
            return refProduct(op, a, b);
        OpDivu, OpDiv:
            return refDivide(op, a, b);
        OpMaddu, OpMadd:
            return hiLo + refProduct(op, a, b);
        OpMsubu, OpMsub:
            return hiLo - refProduct(op, a, b);
        default:
            return hiLo;
    endcase
endfunction

function automatic int refLatency(input mduOp_t op);
    return (op inside {OpDivu, OpDiv}) ? 10 : 5;
endfunction

`endif

/* test/mduTb.sv */
module mduTb
    import mduPkg::*;
();

    localparam int ClkPeriod   = 40;
    localparam int DriveDelay  = 2;
    localparam int ResetCycles = 16;
    localparam int BusyTimeout = 20;
    localparam int Seed        = 2;

    logic      clk;
    logic      reset;
    logic      excHandle;
    mduOp_t    mduOp;
    hiLoMove_t moveHiLo;
    word_t     srcA;
    word_t     srcB;
    logic      mduClr;
    word_t     hi;
    word_t     lo;
    logic      busy;

    // mirror of the architectural HI/LO
    word_t expHi;
    word_t expLo;

    int mismatchCount;
    int failureCount;
    int assertCount;

    `include "mduRefModel.svh"

    mduUnit dut (
        .clk       (clk),
        .reset     (reset),
        .excHandle (excHandle),
        .mduOp     (mduOp),
        .moveHiLo  (moveHiLo),
        .srcA      (srcA),
        .srcB      (srcB),
        .mduClr    (mduClr),
        .hi        (hi),
        .lo        (lo),
        .busy      (busy)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // HI/LO only move at the edge where busy falls
    assert property (@(posedge clk) disable iff (reset)
        (busy && $past(busy)) |-> ($stable(hi) && $stable(lo)))
    else
    begin
        assertCount++;
        $display("hi/lo changed while an operation was still running");
    end

    assert property (@(posedge clk) disable iff (reset)
        (mduClr && busy) |=> (!busy && $stable(hi) && $stable(lo)))
    else
    begin
        assertCount++;
        $display("abort did not drop busy or it disturbed hi/lo");
    end

    // nothing is accepted during an exception
    assert property (@(posedge clk) disable iff (reset)
        (excHandle && !busy) |=> (!busy && $stable(hi) && $stable(lo)))
    else
    begin
        assertCount++;
        $display("command taken while excHandle was high");
    end

    task automatic nextCycle();
        @(posedge clk);
        #(DriveDelay);
    endtask

    task automatic idleInputs();
        mduOp     = mduOp_t'(15);
        moveHiLo  = MoveNone;
        excHandle = 1'b0;
        srcA      = '0;
        srcB      = '0;
    endtask

    task automatic checkValue(input string testName, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected)
        else
        begin
            mismatchCount++;
            $display("MISMATCH %s expected %0h actual %0h", testName, expected, actual);
        end
    endtask

    // random commands that the unit must drop
    task automatic driveNoise();
        mduOp     = mduOp_t'($urandom_range(0, 15));
        moveHiLo  = hiLoMove_t'($urandom_range(0, 3));
        excHandle = 1'($urandom_range(0, 1));
        srcA      = $urandom;
        srcB      = $urandom | 32'd1;
    endtask

    task automatic waitWhileBusy(input string testName, input bit noise, output int cycles);
        cycles = 0;
        while (busy && cycles < BusyTimeout)
        begin
            cycles++;
            if (noise)
                driveNoise();
            nextCycle();
        end
        if (busy)
        begin
            failureCount++;
            $display("%s: busy still high after %0d cycles", testName, cycles);
        end
        idleInputs();
    endtask

    task automatic runOp(input string testName, input mduOp_t op, input word_t a,
                         input word_t b, input bit noise);
        dword_t expected;
        int     cycles;
        expected = refResult(op, a, b, {expHi, expLo});
        mduOp = op;
        srcA  = a;
        srcB  = b;
        nextCycle();
        idleInputs();
        waitWhileBusy(testName, noise, cycles);
        checkValue({testName, " latency"}, refLatency(op), cycles);
        {expHi, expLo} = expected;
        checkValue(testName, {expHi, expLo}, {hi, lo});
    endtask

    task automatic runMove(input string testName, input hiLoMove_t move, input word_t value);
        moveHiLo = move;
        srcA     = value;
        nextCycle();
        idleInputs();
        if (move == MoveHi)
            expHi = value;
        else
            expLo = value;
        checkValue(testName, {expHi, expLo}, {hi, lo});
    endtask

    task automatic runDropped(input string testName);
        excHandle = 1'b1;
        mduOp     = mduOp_t'($urandom_range(0, 7));
        moveHiLo  = ($urandom_range(0, 1) != 0) ? MoveHi : MoveLo;
        srcA      = $urandom;
        srcB      = $urandom | 32'd1;
        nextCycle();
        idleInputs();
        checkValue({testName, " busy"}, 0, busy);
        checkValue(testName, {expHi, expLo}, {hi, lo});
    endtask

    // abort after runCycles further busy cycles
    task automatic runAbort(input string testName, input mduOp_t op, input word_t a,
                            input word_t b, input int runCycles);
        mduOp = op;
        srcA  = a;
        srcB  = b;
        nextCycle();
        idleInputs();
        repeat (runCycles) nextCycle();
        mduClr = 1'b1;
        nextCycle();
        mduClr = 1'b0;
        checkValue({testName, " busy"}, 0, busy);
        checkValue(testName, {expHi, expLo}, {hi, lo});
    endtask

    initial
    begin
        mduOp_t op;
        word_t  divisor;
        void'($urandom(Seed));
        mismatchCount = 0;
        failureCount  = 0;
        assertCount   = 0;
        expHi         = '0;
        expLo         = '0;
        clk           = 1'b0;
        reset         = 1'b1;
        mduClr        = 1'b0;
        idleInputs();
        repeat (ResetCycles) @(posedge clk);
        #(DriveDelay);
        reset = 1'b0;
        checkValue("reset", 0, {hi, lo});
        checkValue("reset busy", 0, busy);

        runOp("multu max", OpMultu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
        runOp("mult neg", OpMult, 32'hFFFF_FFFE, 32'd7, 1'b0);
        runOp("divu", OpDivu, 32'd100, 32'd7, 1'b0);
        runOp("div neg dividend", OpDiv, -32'sd7, 32'sd2, 1'b0);
        runOp("div neg divisor", OpDiv, 32'sd7, -32'sd2, 1'b0);
        runOp("div both neg", OpDiv, -32'sd7, -32'sd2, 1'b0);

        // carry and borrow across the word boundary
        runMove("mthi", MoveHi, 32'h0000_0000);
        runMove("mtlo", MoveLo, 32'hFFFF_FFFF);
        runOp("maddu carry", OpMaddu, 32'd1, 32'd1, 1'b0);
        runOp("msubu borrow", OpMsubu, 32'd1, 32'd1, 1'b0);
        runOp("madd neg", OpMadd, 32'hFFFF_FFFF, 32'd1, 1'b0);
        runOp("msub neg", OpMsub, -32'sd3, 32'sd5, 1'b0);

        runDropped("exc drop 0");
        runDropped("exc drop 1");
        runDropped("exc drop 2");
        runOp("mult busy drop", OpMult, $urandom, $urandom, 1'b1);
        runOp("div busy drop", OpDiv, $urandom, $urandom | 32'd1, 1'b1);

        runAbort("abort mult early", OpMult, $urandom, $urandom, 1);
        runAbort("abort mult last", OpMaddu, $urandom, $urandom, 4);
        runAbort("abort div", OpDiv, $urandom, 32'd3, 8);

        for (int i = 0; i < 48; i++)
        begin
            op      = mduOp_t'($urandom_range(0, 7));
            divisor = $urandom;
            if (divisor == '0)
                divisor = 32'd1;
            runOp($sformatf("random %0d", i), op, $urandom, divisor, (i % 4) == 0);
        end

        $display("errors: %0d mismatches, %0d failures, %0d assertion failures",
                 mismatchCount, failureCount, assertCount);
        if (mismatchCount + failureCount + assertCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+test
common/mduPkg.sv
design/mduIssue.sv
mduCore/mulAccUnit.sv
mduCore/divUnit.sv
mduCore/mduSequencer.sv
design/hiLoFile.sv
design/mduUnit.sv
test/mduTb.sv
